// File: include/exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// datapath width
`define XLEN 32

// machine csr addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// environment call from m-mode
`define MCAUSE_ECALL_M 11

// mstatus fields
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7

`endif

// File: src/exu_isa_pkg.sv
`include "exu_consts.svh"

package exu_isa_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [4:0]       reg_idx_t;
  typedef logic [11:0]      csr_addr_t;

  typedef enum logic [2:0] {
    CLS_ALU,
    CLS_BRANCH,
    CLS_JAL,
    CLS_JALR,
    CLS_LOAD,
    CLS_STORE,
    CLS_SYSTEM
  } instr_class_e;

  // last six are branch compares that only drive cond_o
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [2:0] {
    SYS_CSRRW,
    SYS_CSRRS,
    SYS_CSRRC,
    SYS_ECALL,
    SYS_MRET,
    SYS_EBREAK
  } sys_op_e;

endpackage

// File: src/exu_pipe_pkg.sv
package exu_pipe_pkg;

  import exu_isa_pkg::*;

  // op2 already holds the immediate for immediate alu forms
  typedef struct packed {
    word_t        pc;
    instr_class_e iclass;
    alu_op_e      alu_op;
    sys_op_e      sys_op;
    word_t        op1;
    word_t        op2;
    word_t        imm;
    reg_idx_t     rd;
    csr_addr_t    csr;
  } issue_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    word_t    wb;
    logic     redirect;
    word_t    next_pc;
    logic     halt;
    logic     is_load;
    logic     is_store;
    word_t    mem_addr;
    word_t    store_data;
  } exec_res_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  we;
  } mem_req_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    word_t    wb;
    logic     redirect;
    word_t    next_pc;
    logic     halt;
  } result_t;

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_BUS,
    MEM_HOLD
  } mem_state_e;

endpackage

// File: src/exu_alu.sv
`include "exu_consts.svh"

module exu_alu (
  input  exu_isa_pkg::word_t   a_i,
  input  exu_isa_pkg::word_t   b_i,
  input  exu_isa_pkg::alu_op_e op_i,
  output exu_isa_pkg::word_t   res_o,
  output logic                 cond_o
);
  import exu_isa_pkg::*;

  localparam int SHW = $clog2(`XLEN);

  logic [SHW-1:0] shamt;
  logic           eq;
  logic           lt_s;
  logic           lt_u;

  assign shamt = b_i[SHW-1:0];
  assign eq    = (a_i == b_i);
  assign lt_s  = ($signed(a_i) < $signed(b_i));
  assign lt_u  = (a_i < b_i);

  always_comb begin
    res_o  = '0;
    cond_o = 1'b0;
    case (op_i)
      ALU_ADD:  res_o = a_i + b_i;
      ALU_SUB:  res_o = a_i - b_i;
      ALU_AND:  res_o = a_i & b_i;
      ALU_OR:   res_o = a_i | b_i;
      ALU_XOR:  res_o = a_i ^ b_i;
      ALU_SLL:  res_o = a_i << shamt;
      ALU_SRL:  res_o = a_i >> shamt;
      ALU_SRA:  res_o = word_t'($signed(a_i) >>> shamt);
      ALU_SLT:  res_o = word_t'(lt_s);
      ALU_SLTU: res_o = word_t'(lt_u);
      ALU_EQ:   cond_o = eq;
      ALU_NE:   cond_o = ~eq;
      ALU_LT:   cond_o = lt_s;
      ALU_GE:   cond_o = ~lt_s;
      ALU_LTU:  cond_o = lt_u;
      ALU_GEU:  cond_o = ~lt_u;
      default:  res_o = '0;
    endcase
  end

endmodule

// File: src/exu_csr_file.sv
`include "exu_consts.svh"

module exu_csr_file (
  input  logic                   clk,
  input  logic                   rst,
  input  exu_isa_pkg::csr_addr_t raddr_i,
  output exu_isa_pkg::word_t     rdata_o,
  input  logic                   wen_i,
  input  exu_isa_pkg::sys_op_e   op_i,
  input  exu_isa_pkg::csr_addr_t waddr_i,
  input  exu_isa_pkg::word_t     wsrc_i,
  input  exu_isa_pkg::word_t     trap_pc_i,
  output exu_isa_pkg::word_t     mepc_o,
  output exu_isa_pkg::word_t     mtvec_o
);
  import exu_isa_pkg::*;

  word_t mstatus;
  word_t mtvec;
  word_t mepc;
  word_t mcause;
  word_t wold;
  word_t wval;

  // unknown addresses read as zero
  function automatic word_t csr_read(input csr_addr_t addr);
    case (addr)
      `CSR_MSTATUS: csr_read = mstatus;
      `CSR_MTVEC:   csr_read = mtvec;
      `CSR_MEPC:    csr_read = mepc;
      `CSR_MCAUSE:  csr_read = mcause;
      default:      csr_read = '0;
    endcase
  endfunction

  assign rdata_o = csr_read(raddr_i);
  assign wold    = csr_read(waddr_i);
  assign mepc_o  = mepc;
  assign mtvec_o = mtvec;

  always_comb begin
    case (op_i)
      SYS_CSRRS: wval = wold | wsrc_i;
      SYS_CSRRC: wval = wold & ~wsrc_i;
      default:   wval = wsrc_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (wen_i) begin
      case (op_i)
        SYS_CSRRW, SYS_CSRRS, SYS_CSRRC: begin
          case (waddr_i)
            `CSR_MSTATUS: mstatus <= wval;
            `CSR_MTVEC:   mtvec   <= wval;
            `CSR_MEPC:    mepc    <= wval;
            `CSR_MCAUSE:  mcause  <= wval;
            default:      ;
          endcase
        end
        SYS_ECALL: begin
          mepc                  <= trap_pc_i;
          mcause                <= word_t'(`MCAUSE_ECALL_M);
          mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];
          mstatus[`MSTATUS_MIE]  <= 1'b0;
        end
        SYS_MRET: begin
          mstatus[`MSTATUS_MIE]  <= mstatus[`MSTATUS_MPIE];
          mstatus[`MSTATUS_MPIE] <= 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: src/exu_execute.sv
`include "exu_consts.svh"

module exu_execute (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  exu_pipe_pkg::issue_t   in_issue_i,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output exu_pipe_pkg::exec_res_t out_res_o
);
  import exu_isa_pkg::*;
  import exu_pipe_pkg::*;

  issue_t iss_q;
  logic   valid_q;
  logic   fire_out;
  word_t  alu_res;
  logic   alu_cond;
  word_t  csr_rdata;
  logic   csr_wen;
  word_t  mepc;
  word_t  mtvec;
  word_t  tgt_base;
  word_t  tgt_sum;
  word_t  link;

  // accept when empty or when the current entry leaves this cycle
  assign in_ready_o  = ~valid_q | out_ready_i;
  assign out_valid_o = valid_q;
  assign fire_out    = valid_q & out_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      iss_q <= in_issue_i;
    end
  end

  exu_alu u_alu (
    .a_i    (iss_q.op1),
    .b_i    (iss_q.op2),
    .op_i   (iss_q.alu_op),
    .res_o  (alu_res),
    .cond_o (alu_cond)
  );

  // csr side effects only once, on the hand-off to the memory stage
  assign csr_wen = fire_out && (iss_q.iclass == CLS_SYSTEM);

  exu_csr_file u_csr (
    .clk       (clk),
    .rst       (rst),
    .raddr_i   (iss_q.csr),
    .rdata_o   (csr_rdata),
    .wen_i     (csr_wen),
    .op_i      (iss_q.sys_op),
    .waddr_i   (iss_q.csr),
    .wsrc_i    (iss_q.op1),
    .trap_pc_i (iss_q.pc),
    .mepc_o    (mepc),
    .mtvec_o   (mtvec)
  );

  // one adder for branch/jal targets and register based addresses
  assign tgt_base = (iss_q.iclass == CLS_BRANCH || iss_q.iclass == CLS_JAL) ?
                    iss_q.pc : iss_q.op1;
  assign tgt_sum  = tgt_base + iss_q.imm;
  assign link     = iss_q.pc + word_t'(4);

  always_comb begin
    out_res_o            = '0;
    out_res_o.pc         = iss_q.pc;
    out_res_o.rd         = iss_q.rd;
    out_res_o.next_pc    = link;
    out_res_o.mem_addr   = tgt_sum;
    out_res_o.store_data = iss_q.op2;
    case (iss_q.iclass)
      CLS_ALU: out_res_o.wb = alu_res;
      CLS_BRANCH: begin
        out_res_o.rd       = '0;
        out_res_o.redirect = alu_cond;
        out_res_o.next_pc  = tgt_sum;
      end
      CLS_JAL: begin
        out_res_o.wb       = link;
        out_res_o.redirect = 1'b1;
        out_res_o.next_pc  = tgt_sum;
      end
      CLS_JALR: begin
        out_res_o.wb       = link;
        out_res_o.redirect = 1'b1;
        out_res_o.next_pc  = {tgt_sum[`XLEN-1:1], 1'b0};
      end
      CLS_LOAD:  out_res_o.is_load  = 1'b1;
      CLS_STORE: out_res_o.is_store = 1'b1;
      CLS_SYSTEM: begin
        case (iss_q.sys_op)
          SYS_ECALL: begin
            out_res_o.rd       = '0;
            out_res_o.redirect = 1'b1;
            out_res_o.next_pc  = mtvec;
          end
          SYS_MRET: begin
            out_res_o.rd       = '0;
            out_res_o.redirect = 1'b1;
            out_res_o.next_pc  = mepc;
          end
          SYS_EBREAK: begin
            out_res_o.rd   = '0;
            out_res_o.halt = 1'b1;
          end
          // csr ops return the value before the update
          default: out_res_o.wb = csr_rdata;
        endcase
      end
      default: out_res_o.rd = '0;
    endcase
  end

endmodule

// File: src/exu_mem_stage.sv
module exu_mem_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  exu_pipe_pkg::exec_res_t in_res_i,
  output logic                    mem_req_valid_o,
  output exu_pipe_pkg::mem_req_t  mem_req_o,
  input  logic                    mem_ack_i,
  input  exu_isa_pkg::word_t      mem_rdata_i,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output exu_pipe_pkg::result_t   out_res_o
);
  import exu_pipe_pkg::*;

  mem_state_e state_q;
  exec_res_t  res_q;
  logic       accept;
  logic       in_is_mem;

  // a new entry may come in while the held result leaves
  assign in_ready_o = (state_q == MEM_IDLE) || (state_q == MEM_HOLD && out_ready_i);
  assign accept     = in_valid_i & in_ready_o;
  assign in_is_mem  = in_res_i.is_load | in_res_i.is_store;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= MEM_IDLE;
    end else if (accept) begin
      state_q <= in_is_mem ? MEM_BUS : MEM_HOLD;
    end else if (state_q == MEM_BUS && mem_ack_i) begin
      state_q <= MEM_HOLD;
    end else if (state_q == MEM_HOLD && out_ready_i) begin
      state_q <= MEM_IDLE;
    end
  end

  // load data sampled with the ack
  always_ff @(posedge clk) begin
    if (accept) begin
      res_q <= in_res_i;
    end else if (state_q == MEM_BUS && mem_ack_i && res_q.is_load) begin
      res_q.wb <= mem_rdata_i;
    end
  end

  assign mem_req_valid_o = (state_q == MEM_BUS);
  assign mem_req_o.addr  = res_q.mem_addr;
  assign mem_req_o.wdata = res_q.store_data;
  assign mem_req_o.we    = res_q.is_store;

  assign out_valid_o        = (state_q == MEM_HOLD);
  assign out_res_o.pc       = res_q.pc;
  // stores have no write-back
  assign out_res_o.rd       = res_q.is_store ? '0 : res_q.rd;
  assign out_res_o.wb       = res_q.wb;
  assign out_res_o.redirect = res_q.redirect;
  assign out_res_o.next_pc  = res_q.next_pc;
  assign out_res_o.halt     = res_q.halt;

endmodule

// File: src/exu_top.sv
module exu_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  exu_pipe_pkg::issue_t   in_issue_i,
  output logic                   mem_req_valid_o,
  output exu_pipe_pkg::mem_req_t mem_req_o,
  input  logic                   mem_ack_i,
  input  exu_isa_pkg::word_t     mem_rdata_i,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output exu_pipe_pkg::result_t  out_res_o
);
  import exu_pipe_pkg::*;

  logic      ex_valid;
  logic      ex_ready;
  exec_res_t ex_res;

  exu_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_issue_i  (in_issue_i),
    .out_valid_o (ex_valid),
    .out_ready_i (ex_ready),
    .out_res_o   (ex_res)
  );

  exu_mem_stage u_mem (
    .clk             (clk),
    .rst             (rst),
    .in_valid_i      (ex_valid),
    .in_ready_o      (ex_ready),
    .in_res_i        (ex_res),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rdata_i     (mem_rdata_i),
    .out_valid_o     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .out_res_o       (out_res_o)
  );

endmodule

// File: verification/exu_tb_model.sv
`include "exu_consts.svh"

package exu_tb_model;

  import exu_isa_pkg::*;
  import exu_pipe_pkg::*;

  localparam word_t       MEM_BASE  = 32'h0000_1000;
  localparam int unsigned MEM_WORDS = 64;
  localparam word_t       SIGN_BIT  = 32'h8000_0000;

  word_t csr_mstatus;
  word_t csr_mtvec;
  word_t csr_mepc;
  word_t csr_mcause;
  word_t data_mem [MEM_WORDS];

  // every bit of the byte address feeds the pattern
  function automatic word_t fill_word(input int unsigned idx);
    word_t addr;
    addr = MEM_BASE + word_t'(idx * 4);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  function automatic void model_reset();
    csr_mstatus = '0;
    csr_mtvec   = '0;
    csr_mepc    = '0;
    csr_mcause  = '0;
    for (int unsigned i = 0; i < MEM_WORDS; i++) begin
      data_mem[i] = fill_word(i);
    end
  endfunction

  function automatic word_t alu_calc(input alu_op_e op, input word_t a, input word_t b);
    int unsigned sh;
    sh = b % 32;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + 32'd1;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      // sign fill of the vacated upper bits
      ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      ALU_SLT:  return ((a ^ SIGN_BIT) < (b ^ SIGN_BIT)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:  return '0;
    endcase
  endfunction

  function automatic bit branch_taken(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return (a ^ SIGN_BIT) < (b ^ SIGN_BIT);
      ALU_GE:  return (a ^ SIGN_BIT) >= (b ^ SIGN_BIT);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t csr_get(input csr_addr_t addr);
    case (addr)
      `CSR_MSTATUS: return csr_mstatus;
      `CSR_MTVEC:   return csr_mtvec;
      `CSR_MEPC:    return csr_mepc;
      `CSR_MCAUSE:  return csr_mcause;
      default:      return '0;
    endcase
  endfunction

  function automatic void csr_put(input csr_addr_t addr, input word_t val);
    case (addr)
      `CSR_MSTATUS: csr_mstatus = val;
      `CSR_MTVEC:   csr_mtvec   = val;
      `CSR_MEPC:    csr_mepc    = val;
      `CSR_MCAUSE:  csr_mcause  = val;
      default:      ;
    endcase
  endfunction

  // called once per instruction, in program order
  function automatic result_t predict(input issue_t iss);
    result_t     r;
    word_t       old;
    word_t       addr;
    int unsigned idx;
    logic        mie;
    r    = '0;
    r.pc = iss.pc;
    r.rd = iss.rd;
    addr = iss.op1 + iss.imm;
    idx  = (addr - MEM_BASE) >> 2;
    case (iss.iclass)
      CLS_ALU: r.wb = alu_calc(iss.alu_op, iss.op1, iss.op2);
      CLS_BRANCH: begin
        r.rd       = '0;
        r.redirect = branch_taken(iss.alu_op, iss.op1, iss.op2);
        r.next_pc  = iss.pc + iss.imm;
      end
      CLS_JAL: begin
        r.wb       = iss.pc + 32'd4;
        r.redirect = 1'b1;
        r.next_pc  = iss.pc + iss.imm;
      end
      CLS_JALR: begin
        r.wb       = iss.pc + 32'd4;
        r.redirect = 1'b1;
        r.next_pc  = addr & ~32'h1;
      end
      CLS_LOAD: r.wb = data_mem[idx];
      CLS_STORE: begin
        data_mem[idx] = iss.op2;
        r.rd          = '0;
      end
      default: begin
        case (iss.sys_op)
          SYS_CSRRW, SYS_CSRRS, SYS_CSRRC: begin
            old  = csr_get(iss.csr);
            r.wb = old;
            if (iss.sys_op == SYS_CSRRW) csr_put(iss.csr, iss.op1);
            else if (iss.sys_op == SYS_CSRRS) csr_put(iss.csr, old | iss.op1);
            else csr_put(iss.csr, old & ~iss.op1);
          end
          SYS_ECALL: begin
            r.rd       = '0;
            r.redirect = 1'b1;
            r.next_pc  = csr_mtvec;
            csr_mepc   = iss.pc;
            csr_mcause = `MCAUSE_ECALL_M;
            mie        = csr_mstatus[`MSTATUS_MIE];
            csr_mstatus[`MSTATUS_MPIE] = mie;
            csr_mstatus[`MSTATUS_MIE]  = 1'b0;
          end
          SYS_MRET: begin
            r.rd       = '0;
            r.redirect = 1'b1;
            r.next_pc  = csr_mepc;
            csr_mstatus[`MSTATUS_MIE]  = csr_mstatus[`MSTATUS_MPIE];
            csr_mstatus[`MSTATUS_MPIE] = 1'b1;
          end
          default: begin
            r.rd   = '0;
            r.halt = 1'b1;
          end
        endcase
      end
    endcase
    return r;
  endfunction

endpackage

// File: verification/exu_assert.sv
module exu_assert (
  input logic                   clk,
  input logic                   rst,
  input logic                   mem_req_valid_i,
  input exu_pipe_pkg::mem_req_t mem_req_i,
  input logic                   mem_ack_i,
  input logic                   out_valid_i,
  input logic                   out_ready_i,
  input exu_pipe_pkg::result_t  out_res_i
);

  int unsigned fail_cnt = 0;

  req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid_i && !mem_ack_i |=> mem_req_valid_i && $stable(mem_req_i))
    else begin
      fail_cnt++;
      $error("bus request dropped or changed before its acknowledge");
    end

  ack_in_req: assert property (@(posedge clk) disable iff (rst)
    mem_ack_i |-> mem_req_valid_i)
    else begin
      fail_cnt++;
      $error("bus acknowledge without a pending request");
    end

  // stalled result must not move
  out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_res_i))
    else begin
      fail_cnt++;
      $error("result valid or payload changed while stalled");
    end

endmodule

bind exu_top exu_assert u_assert (
  .clk             (clk),
  .rst             (rst),
  .mem_req_valid_i (mem_req_valid_o),
  .mem_req_i       (mem_req_o),
  .mem_ack_i       (mem_ack_i),
  .out_valid_i     (out_valid_o),
  .out_ready_i     (out_ready_i),
  .out_res_i       (out_res_o)
);

// File: verification/exu_tb.sv
module exu_tb;
  import exu_isa_pkg::*;
  import exu_pipe_pkg::*;
  import exu_tb_model::*;

  localparam int N_INSTR        = 400;
  localparam int TIMEOUT_CYCLES = N_INSTR * 12;

  logic     clk;
  logic     rst;
  logic     in_valid_i;
  logic     in_ready_o;
  issue_t   in_issue_i;
  logic     mem_req_valid_o;
  mem_req_t mem_req_o;
  logic     mem_ack_i;
  word_t    mem_rdata_i;
  logic     out_valid_o;
  logic     out_ready_i;
  result_t  out_res_o;

  result_t     exp_q[$];
  word_t       bus_mem [MEM_WORDS];
  int          err_cnt = 0;
  int          n_issued = 0;
  int          out_cnt = 0;
  int          cycles = 0;
  bit          busy = 1'b0;
  int unsigned ack_wait = 0;

  exu_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic issue_t make_issue();
    issue_t      iss;
    word_t       r;
    int unsigned slot;
    iss        = '0;
    r          = $urandom;
    iss.pc     = $urandom & 32'hffff_fffc;
    iss.imm    = {{20{r[11]}}, r[11:0]};
    iss.rd     = reg_idx_t'($urandom_range(31, 1));
    iss.op1    = $urandom;
    iss.op2    = $urandom;
    iss.iclass = instr_class_e'($urandom_range(6));
    case (iss.iclass)
      CLS_ALU: iss.alu_op = alu_op_e'($urandom_range(9));
      CLS_BRANCH: begin
        iss.alu_op = alu_op_e'($urandom_range(15, 10));
        if ($urandom_range(3) == 0) iss.op2 = iss.op1;
      end
      CLS_LOAD, CLS_STORE: begin
        slot    = $urandom_range(MEM_WORDS - 1);
        iss.op1 = MEM_BASE + $urandom_range(255);
        iss.imm = MEM_BASE + slot * 4 - iss.op1;
      end
      CLS_SYSTEM: begin
        iss.sys_op = sys_op_e'($urandom_range(5));
        case ($urandom_range(3))
          0:       iss.csr = `CSR_MSTATUS;
          1:       iss.csr = `CSR_MTVEC;
          2:       iss.csr = `CSR_MEPC;
          default: iss.csr = `CSR_MCAUSE;
        endcase
      end
      default: ;
    endcase
    return iss;
  endfunction

  task automatic check_result(input result_t got);
    result_t exp;
    if (exp_q.size() == 0) begin
      $display("ERR %0t: result for pc %h with nothing pending", $time, got.pc);
      err_cnt++;
    end else begin
      exp = exp_q.pop_front();
      if (got.pc !== exp.pc) begin
        $display("ERR %0t: pc %h, expected %h", $time, got.pc, exp.pc);
        err_cnt++;
      end
      if (got.rd !== exp.rd) begin
        $display("ERR %0t: pc %h rd %0d, expected %0d", $time, exp.pc, got.rd, exp.rd);
        err_cnt++;
      end
      // x0 write-back is discarded
      if (exp.rd != 0 && got.wb !== exp.wb) begin
        $display("ERR %0t: pc %h wb %h, expected %h", $time, exp.pc, got.wb, exp.wb);
        err_cnt++;
      end
      if (got.redirect !== exp.redirect || got.halt !== exp.halt) begin
        $display("ERR %0t: pc %h redirect/halt %b%b, expected %b%b", $time, exp.pc,
                 got.redirect, got.halt, exp.redirect, exp.halt);
        err_cnt++;
      end
      if (exp.redirect && got.next_pc !== exp.next_pc) begin
        $display("ERR %0t: pc %h next pc %h, expected %h", $time, exp.pc, got.next_pc,
                 exp.next_pc);
        err_cnt++;
      end
    end
    out_cnt++;
  endtask

  task automatic serve_bus(input mem_req_t req);
    int unsigned idx;
    idx = (req.addr - MEM_BASE) >> 2;
    if (req.addr[1:0] != 2'b00 || idx >= MEM_WORDS) begin
      $display("bus access at %h falls outside the data window", req.addr);
      err_cnt++;
    end else if (req.we) begin
      bus_mem[idx] = req.wdata;
    end else begin
      mem_rdata_i <= bus_mem[idx];
    end
    mem_ack_i <= 1'b1;
  endtask

  task automatic finish_run();
    int unsigned n_assert;
    n_assert = DUT.u_assert.fail_cnt;
    $display("errors %0d, assertion failures %0d, issued %0d, results %0d", err_cnt,
             n_assert, n_issued, out_cnt);
    if (err_cnt == 0 && n_assert == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  // random back-pressure on the result port
  always @(posedge clk) begin
    if (!rst) begin
      if (out_valid_o && out_ready_i) check_result(out_res_o);
      out_ready_i <= ($urandom_range(3) != 0);
    end
  end

  // bus responder with 0 to 4 cycles of delay
  always @(posedge clk) begin
    if (mem_ack_i) begin
      mem_ack_i <= 1'b0;
    end else if (!rst && mem_req_valid_o) begin
      if (!busy) begin
        busy     = 1'b1;
        ack_wait = $urandom_range(4);
      end
      if (ack_wait == 0) begin
        serve_bus(mem_req_o);
        busy = 1'b0;
      end else begin
        ack_wait--;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("run timed out after %0d cycles with %0d of %0d results", cycles, out_cnt,
                 N_INSTR);
        err_cnt++;
        finish_run();
      end
    end
  end

  initial begin
    issue_t iss;
    void'($urandom(81));
    rst         = 1'b1;
    in_valid_i  = 1'b0;
    in_issue_i  = '0;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    out_ready_i = 1'b0;
    model_reset();
    for (int i = 0; i < MEM_WORDS; i++) bus_mem[i] = fill_word(i);
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    if (out_valid_o !== 1'b0 || mem_req_valid_o !== 1'b0 || in_ready_o !== 1'b1) begin
      $display("ERR %0t: after reset out_valid %b req_valid %b in_ready %b", $time,
               out_valid_o, mem_req_valid_o, in_ready_o);
      err_cnt++;
    end
    for (int n = 0; n < N_INSTR; n++) begin
      iss = make_issue();
      exp_q.push_back(predict(iss));
      in_valid_i <= 1'b1;
      in_issue_i <= iss;
      @(posedge clk);
      while (!in_ready_o) @(posedge clk);
      n_issued++;
      if ($urandom_range(3) == 0) begin
        in_valid_i <= 1'b0;
        @(posedge clk);
      end
    end
    in_valid_i <= 1'b0;
    while (out_cnt < N_INSTR) @(posedge clk);
    repeat (20) @(posedge clk);
    if (out_cnt != n_issued || exp_q.size() != 0) begin
      $display("result count %0d does not match %0d issued instructions", out_cnt, n_issued);
      err_cnt++;
    end
    finish_run();
  end

endmodule

// File: files.f
+incdir+include
src/exu_isa_pkg.sv
src/exu_pipe_pkg.sv
src/exu_alu.sv
src/exu_csr_file.sv
src/exu_execute.sv
src/exu_mem_stage.sv
src/exu_top.sv
verification/exu_tb_model.sv
verification/exu_assert.sv
verification/exu_tb.sv

// File: Bender.yml
package:
  name: exu

sources:
  - include_dirs:
      - include
    files:
      - src/exu_isa_pkg.sv
      - src/exu_pipe_pkg.sv
      - src/exu_alu.sv
      - src/exu_csr_file.sv
      - src/exu_execute.sv
      - src/exu_mem_stage.sv
      - src/exu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/exu_tb_model.sv
      - verification/exu_assert.sv
      - verification/exu_tb.sv
